// ==== bench/tb_rv_decode.sv ====
`default_nettype none

module tb_rv_decode import rv_decode_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int first_count = 300;   // Instructions before the EBREAK
    localparam int second_count = 20;   // Instructions before the JAL
    localparam int sweep_cycles = 32;
    localparam int reset_cycles = 10;
    localparam int cycle_limit = 40 * (first_count + second_count + 2) +
                                 2 * (reset_cycles + sweep_cycles + 1);

    typedef struct packed {
        exec_type_t typ;
        funct3_t    f3;
        logic       alt;
        reg_addr_t  rd;
        reg_value_t a;
        reg_value_t b;
        reg_value_t sv;
        reg_value_t pc;
    } cmd_t;

    logic        clk, rst;
    logic        in_valid, in_ready, ex_valid, ex_ready;
    reg_value_t  in_inst, in_pc;
    exec_type_t  ex_type;
    funct3_t     ex_funct3;
    logic        ex_alt;
    reg_addr_t   ex_rd;
    reg_value_t  ex_operand_a, ex_operand_b, ex_store_value, ex_pc;
    logic        wb_valid;
    reg_addr_t   wb_addr;
    reg_value_t  wb_value;
    logic        halted, faulted, finished;

    // Reference model state
    reg_value_t  regs [reg_count];
    int          pend [reg_count];
    logic        model_normal, model_halt, model_fault, model_slot;
    cmd_t        exp_q [$];

    // Fields of the instruction currently on in_inst
    inst_class_t cur_class;
    reg_addr_t   cur_rd, cur_rs1, cur_rs2;
    funct3_t     cur_f3;
    logic        cur_alt, cur_auipc;
    reg_value_t  cur_imm;

    logic [15:0] lfsr;
    reg_value_t  pc_counter;
    int          gen_left;
    logic        special_armed;
    reg_value_t  special_inst;
    inst_class_t special_class;
    int          cycle_count;

    rv_decode u_rv_decode (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_inst(in_inst), .in_pc(in_pc), .in_ready(in_ready),
        .ex_valid(ex_valid), .ex_ready(ex_ready), .ex_type(ex_type),
        .ex_funct3(ex_funct3), .ex_alt(ex_alt), .ex_rd(ex_rd),
        .ex_operand_a(ex_operand_a), .ex_operand_b(ex_operand_b),
        .ex_store_value(ex_store_value), .ex_pc(ex_pc),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_value(wb_value),
        .halted(halted), .faulted(faulted), .finished(finished)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            report_error("Timeout, the run did not finish within the cycle limit");
        end
    end

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_error(string what);
        $display("Error at %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic src1_used(inst_class_t cls);
        return cls == ALU_REG || cls == ALU_IMM || cls == LOAD || cls == STORE;
    endfunction

    function automatic logic src2_used(inst_class_t cls);
        return cls == ALU_REG || cls == STORE;
    endfunction

    function automatic logic dest_written(inst_class_t cls, reg_addr_t rd);
        return (cls == ALU_REG || cls == ALU_IMM || cls == UPPER || cls == LOAD) && rd != 0;
    endfunction

    function automatic logic no_pending();
        for (int i = 0; i < reg_count; i++) begin
            if (pend[i] != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic logic issue_allowed();
        if (src1_used(cur_class) && pend[cur_rs1] != 0) return 1'b0;
        if (src2_used(cur_class) && pend[cur_rs2] != 0) return 1'b0;
        if (dest_written(cur_class, cur_rd) && pend[cur_rd] >= 2) return 1'b0;
        return 1'b1;
    endfunction

    task automatic set_fields(reg_value_t inst, inst_class_t cls);
        cur_class = cls;
        cur_rd    = inst[11:7];
        cur_f3    = inst[14:12];
        cur_rs1   = inst[19:15];
        cur_rs2   = inst[24:20];
        in_inst  <= inst;
        in_pc    <= pc_counter;
        in_valid <= 1'b1;
        pc_counter = pc_counter + 4;
    endtask

    // Random instruction from the six kept classes, registers x0..x7
    task automatic gen_inst();
        reg_addr_t   rd, rs1, rs2;
        funct3_t     f3;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [6:0]  f7;
        int          sel;
        reg_value_t  inst;
        inst_class_t cls;
        rd    = reg_addr_t'(rand_bits(3));
        rs1   = reg_addr_t'(rand_bits(3));
        rs2   = reg_addr_t'(rand_bits(3));
        f3    = funct3_t'(rand_bits(3));
        imm12 = 12'(rand_bits(12));
        imm20 = 20'(rand_bits(20));
        sel   = int'(rand_bits(8)) % 6;
        cur_alt   = 1'b0;
        cur_auipc = 1'b0;
        cur_imm   = {{20{imm12[11]}}, imm12};
        case (sel)
            0: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? 7'b0100000 : 7'b0;
                inst = {f7, rs2, rs1, f3, rd, 7'b0110011};
                cls = ALU_REG;
                cur_alt = f7 == 7'b0100000;
            end
            1: begin
                if (f3 == 3'd1) imm12[11:5] = 7'b0;  // SLLI
                if (f3 == 3'd5) imm12[11:5] = rand_bits(1) != 0 ? 7'b0100000 : 7'b0;
                inst = {imm12, rs1, f3, rd, 7'b0010011};
                cls = ALU_IMM;
                cur_alt = f3 == 3'd5 && imm12[11:5] == 7'b0100000;
                cur_imm = {{20{imm12[11]}}, imm12};
            end
            2, 3: begin
                cur_auipc = sel == 3;
                inst = {imm20, rd, cur_auipc ? 7'b0010111 : 7'b0110111};
                cls = UPPER;
                cur_imm = {imm20, 12'b0};
            end
            4: begin
                inst = {imm12, rs1, f3, rd, 7'b0000011};
                cls = LOAD;
            end
            default: begin
                inst = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
                cls = STORE;
            end
        endcase
        set_fields(inst, cls);
    endtask

    // One clock of checks, model update and new stimulus
    task automatic step();
        logic pred, accepted, send, all_zero, alu, exp_finished;
        cmd_t c, h;
        int   start, idx, pick;
        @(posedge clk);
        all_zero = no_pending();
        exp_finished = (model_halt || model_fault) && all_zero;
        pred = model_normal && issue_allowed() && (!model_slot || ex_ready);
        assert (in_ready === pred) else report_mismatch("in_ready", 32'(pred), 32'(in_ready));
        assert (ex_valid === model_slot)
            else report_mismatch("ex_valid", 32'(model_slot), 32'(ex_valid));
        assert (halted === model_halt)
            else report_mismatch("halted", 32'(model_halt), 32'(halted));
        assert (faulted === model_fault)
            else report_mismatch("faulted", 32'(model_fault), 32'(faulted));
        assert (finished === exp_finished)
            else report_mismatch("finished", 32'(exp_finished), 32'(finished));

        if (ex_valid && ex_ready) begin
            assert (exp_q.size() != 0) else report_error("Command sent with none expected");
            h = exp_q.pop_front();
            assert (ex_type === h.typ) else report_mismatch("ex_type", 32'(h.typ), 32'(ex_type));
            assert (ex_funct3 === h.f3)
                else report_mismatch("ex_funct3", 32'(h.f3), 32'(ex_funct3));
            assert (ex_alt === h.alt) else report_mismatch("ex_alt", 32'(h.alt), 32'(ex_alt));
            assert (ex_rd === h.rd) else report_mismatch("ex_rd", 32'(h.rd), 32'(ex_rd));
            assert (ex_operand_a === h.a) else report_mismatch("ex_operand_a", h.a, ex_operand_a);
            assert (ex_operand_b === h.b) else report_mismatch("ex_operand_b", h.b, ex_operand_b);
            assert (ex_store_value === h.sv)
                else report_mismatch("ex_store_value", h.sv, ex_store_value);
            assert (ex_pc === h.pc) else report_mismatch("ex_pc", h.pc, ex_pc);
        end

        accepted = in_valid && in_ready;
        send = 1'b0;
        if (accepted) begin
            if (cur_class == HALT) begin
                model_halt   = 1'b1;
                model_normal = 1'b0;
            end else if (cur_class == ILLEGAL) begin
                model_fault  = 1'b1;
                model_normal = 1'b0;
            end else begin
                alu   = cur_class == ALU_REG || cur_class == ALU_IMM || cur_class == UPPER;
                c.typ = cur_class == LOAD ? EXEC_LOAD : cur_class == STORE ? EXEC_STORE : EXEC_ALU;
                c.f3  = cur_class == UPPER ? 3'd0 : cur_f3;
                c.alt = cur_alt;
                c.rd  = dest_written(cur_class, cur_rd) ? cur_rd : 5'd0;
                c.a   = cur_class == UPPER ? (cur_auipc ? in_pc : '0) : regs[cur_rs1];
                c.b   = cur_class == ALU_REG ? regs[cur_rs2] : cur_imm;
                c.sv  = regs[cur_rs2];
                c.pc  = in_pc;
                send  = !(alu && cur_rd == 0);  // ALU result to x0 is dropped
                if (send) exp_q.push_back(c);
                if (dest_written(cur_class, cur_rd)) pend[cur_rd]++;
            end
        end
        if (wb_valid && wb_addr != 0) begin
            pend[wb_addr]--;
            regs[wb_addr] = wb_value;
        end
        model_slot = send || (model_slot && !ex_ready);

        if (accepted || !in_valid) begin
            if (gen_left > 0 && rand_bits(2) != 0) begin
                gen_inst();
                gen_left--;
            end else if (gen_left == 0 && special_armed) begin
                set_fields(special_inst, special_class);
                special_armed = 1'b0;
            end else begin
                in_valid <= 1'b0;
            end
        end

        // Retire a random pending register
        pick = 0;
        start = int'(rand_bits(3));
        for (int k = 0; k < 8; k++) begin
            idx = (start + k) % 8;
            if (pick == 0 && idx != 0 && pend[idx] > 0) pick = idx;
        end
        if (pick != 0 && rand_bits(2) != 0) begin
            wb_valid <= 1'b1;
            wb_addr  <= reg_addr_t'(pick);
            wb_value <= rand_bits(32);
        end else begin
            wb_valid <= 1'b0;
        end
        ex_ready <= rand_bits(2) != 0;
    endtask

    task automatic reset_and_sweep();
        rst      <= 1'b1;
        in_valid <= 1'b0;
        in_inst  <= '0;
        wb_valid <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        // Sweep, then one cycle in RESET while the FSM moves to NORMAL
        repeat (sweep_cycles + 1) begin
            @(posedge clk);
            assert (in_ready === 1'b0) else report_mismatch("in_ready", 32'd0, 32'(in_ready));
        end
        for (int i = 0; i < reg_count; i++) begin
            regs[i] = '0;  // Sweep leaves every register at zero
            pend[i] = 0;
        end
        exp_q.delete();
        model_normal = 1'b1;
        model_halt   = 1'b0;
        model_fault  = 1'b0;
        model_slot   = 1'b0;
        cur_class    = ILLEGAL;  // in_inst is zero, an unknown opcode
        cur_rd       = '0;
        cur_rs1      = '0;
        cur_rs2      = '0;
    endtask

    task automatic drain();
        while (!no_pending() || exp_q.size() != 0 || model_slot) step();
        step();
        assert (finished === 1'b1 && in_ready === 1'b0)
            else report_error("finished not raised with in_ready low after draining");
    endtask

    initial begin
        lfsr        = 16'd65;
        cycle_count = 0;
        pc_counter  = 32'h0000_1000;
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_inst     = '0;
        in_pc       = '0;
        ex_ready    = 1'b0;
        wb_valid    = 1'b0;
        wb_addr     = '0;
        wb_value    = '0;

        // Random traffic, then EBREAK
        reset_and_sweep();
        gen_left      = first_count;
        special_inst  = 32'h0010_0073;
        special_class = HALT;
        special_armed = 1'b1;
        while (!model_halt) step();
        drain();
        assert (halted === 1'b1) else report_error("halted not set after EBREAK");

        // Second run ends on a JAL
        reset_and_sweep();
        gen_left      = second_count;
        special_inst  = {20'h0, 5'd1, 7'b1101111};
        special_class = ILLEGAL;
        special_armed = 1'b1;
        while (!model_fault) step();
        drain();
        assert (faulted === 1'b1) else report_error("faulted not set after JAL");

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/decode_control.sv ====
`default_nettype none

module decode_control
    import rv_decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        in_valid,
    input  reg_value_t  in_pc,
    output logic        in_ready,

    input  logic        clearing,
    input  logic        issue_ok,
    input  logic        all_clear,
    output logic        issue,

    input  reg_addr_t   rd,
    input  funct3_t     funct3,
    input  logic        alt,
    input  reg_value_t  imm,
    input  inst_class_t inst_class,
    input  logic        writes_rd,
    input  reg_value_t  rs1_value,
    input  reg_value_t  rs2_value,

    output logic        ex_valid,
    input  logic        ex_ready,
    output exec_type_t  ex_type,
    output funct3_t     ex_funct3,
    output logic        ex_alt,
    output reg_addr_t   ex_rd,
    output reg_value_t  ex_operand_a,
    output reg_value_t  ex_operand_b,
    output reg_value_t  ex_store_value,
    output reg_value_t  ex_pc,

    output logic        halted,
    output logic        faulted,
    output logic        finished
);

    typedef enum logic [1:0] {
        ST_RESET  = 2'd0,
        ST_NORMAL = 2'd1,
        ST_HALT   = 2'd2,
        ST_FAULT  = 2'd3
    } state_t;

    state_t     state, next_state;
    logic       accept, send, alu_class;
    exec_type_t cmd_type;
    funct3_t    cmd_funct3;
    logic       cmd_alt;
    reg_value_t cmd_operand_a, cmd_operand_b;

    // Accept only in NORMAL, with a free or emptying output slot
    assign in_ready = state == ST_NORMAL && issue_ok && (!ex_valid || ex_ready);
    assign accept   = in_valid && in_ready;

    assign alu_class = inst_class inside {ALU_REG, ALU_IMM, UPPER};
    assign issue     = accept && inst_class inside {ALU_REG, ALU_IMM, UPPER, LOAD, STORE};
    assign send      = issue && !(alu_class && rd == '0); // ALU results to x0 vanish

    always_comb begin
        next_state = state;
        if (state == ST_RESET && !clearing) begin
            next_state = ST_NORMAL;
        end
        if (accept && inst_class == HALT) begin
            next_state = ST_HALT;
        end else if (accept && inst_class == ILLEGAL) begin
            next_state = ST_FAULT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        cmd_type      = EXEC_ALU;
        cmd_funct3    = funct3;
        cmd_alt       = alt;
        cmd_operand_a = rs1_value;
        cmd_operand_b = imm;
        case (inst_class)
            ALU_REG: cmd_operand_b = rs2_value;
            UPPER: begin
                cmd_funct3    = funct3_add;
                cmd_alt       = 1'b0;
                cmd_operand_a = alt ? in_pc : '0;   // AUIPC adds to pc, LUI to zero
            end
            LOAD:  cmd_type = EXEC_LOAD;
            STORE: cmd_type = EXEC_STORE;
            default: ;
        endcase
    end

    // Output slot, a new command replaces a taken one without a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (send) begin
            ex_valid <= 1'b1;
        end else if (ex_ready) begin
            ex_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            ex_type        <= cmd_type;
            ex_funct3      <= cmd_funct3;
            ex_alt         <= cmd_alt;
            ex_rd          <= writes_rd ? rd : '0;
            ex_operand_a   <= cmd_operand_a;
            ex_operand_b   <= cmd_operand_b;
            ex_store_value <= rs2_value;
            ex_pc          <= in_pc;
        end
    end

    assign halted   = state == ST_HALT;
    assign faulted  = state == ST_FAULT;
    assign finished = (halted || faulted) && all_clear;

    // Held command must not change under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_type) && $stable(ex_funct3) &&
            $stable(ex_alt) && $stable(ex_rd) && $stable(ex_operand_a) &&
            $stable(ex_operand_b) && $stable(ex_store_value) && $stable(ex_pc))
        else $error("Execute command changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/decode_fields.sv ====
`default_nettype none

module decode_fields
    import rv_decode_pkg::*;
(
    input  reg_value_t  inst,

    output reg_addr_t   rd,
    output reg_addr_t   rs1,
    output reg_addr_t   rs2,
    output funct3_t     funct3,
    output logic        alt,
    output reg_value_t  imm,
    output inst_class_t inst_class,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic        writes_rd
);

    opcode_t     opcode;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        is_ebreak;
    reg_value_t  imm_i, imm_s, imm_u;

    assign opcode  = opcode_t'(inst[6:0]);
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign rs1     = inst[19:15];
    assign rs2     = inst[24:20];
    assign funct7  = inst[31:25];
    assign funct12 = inst[31:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    // Plain EBREAK only, any other SYSTEM encoding faults
    assign is_ebreak = funct12 == ebreak_funct12 && funct3 == funct3_add &&
                       rs1 == '0 && rd == '0;

    always_comb begin
        inst_class = ILLEGAL;
        imm        = imm_i;
        alt        = 1'b0;
        case (opcode)
            OPC_OP: begin
                inst_class = ALU_REG;
                alt        = funct7 == funct7_alt;
            end
            OPC_IMM: begin
                inst_class = ALU_IMM;
                // Only SRAI has an alternate form among the immediates
                alt        = funct7 == funct7_alt && funct3 == funct3_srl_sra;
            end
            OPC_LUI: begin
                inst_class = UPPER;
                imm        = imm_u;
            end
            OPC_AUIPC: begin
                inst_class = UPPER;
                imm        = imm_u;
                alt        = 1'b1;  // UPPER uses alt as the pc-relative marker
            end
            OPC_LOAD:  inst_class = LOAD;
            OPC_STORE: begin
                inst_class = STORE;
                imm        = imm_s;
            end
            OPC_SYSTEM: inst_class = is_ebreak ? HALT : ILLEGAL;
            OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_FENCE: inst_class = ILLEGAL;
            default: inst_class = ILLEGAL;
        endcase
    end

    assign uses_rs1  = inst_class inside {ALU_REG, ALU_IMM, LOAD, STORE};
    assign uses_rs2  = inst_class inside {ALU_REG, STORE};
    assign writes_rd = inst_class inside {ALU_REG, ALU_IMM, UPPER, LOAD} && rd != '0;

endmodule

`default_nettype wire

// ==== hdl/decode_reg_file.sv ====
`default_nettype none

module decode_reg_file
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  reg_addr_t  rd_addr_a,
    input  reg_addr_t  rd_addr_b,
    output reg_value_t rd_value_a,
    output reg_value_t rd_value_b,

    input  logic       wr_en,
    input  reg_addr_t  wr_addr,
    input  reg_value_t wr_value,

    output logic       clearing
);

    reg_value_t regs [reg_count];
    reg_addr_t  sweep_addr;

    // Zeroing sweep, one register per cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_addr <= '0;
            clearing   <= 1'b1;
        end else if (clearing) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (sweep_addr == reg_addr_t'(reg_count - 1)) begin
                clearing <= 1'b0; // Last register written this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            regs[sweep_addr] <= '0;
        end else if (wr_en && wr_addr != '0) begin    // x0 stays zero
            regs[wr_addr] <= wr_value;
        end
    end

    assign rd_value_a = regs[rd_addr_a];
    assign rd_value_b = regs[rd_addr_b];

    // Nothing can be pending during the sweep, so no writeback either
    assert property (@(posedge clk) disable iff (rst) !(wr_en && clearing))
        else $error("Writeback during register clearing");

endmodule

`default_nettype wire

// ==== hdl/decode_scoreboard.sv ====
`default_nettype none

module decode_scoreboard
    import rv_decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      uses_rs1,
    input  logic      uses_rs2,
    input  logic      writes_rd,
    input  logic      issue,

    input  logic      wb_valid,
    input  reg_addr_t wb_addr,

    output logic      issue_ok,
    output logic      all_clear
);

    pend_count_t pending [reg_count];
    logic        rs1_busy, rs2_busy, rd_full;

    // Sources must be settled, destination needs a free slot
    assign rs1_busy = uses_rs1 && pending[rs1] != '0;
    assign rs2_busy = uses_rs2 && pending[rs2] != '0;
    assign rd_full  = writes_rd && pending[rd] >= max_pending;
    assign issue_ok = !rs1_busy && !rs2_busy && !rd_full;

    for (genvar i = 0; i < reg_count; i++) begin : g_count
        logic inc, dec;

        // writes_rd is never set for x0, so x0 stays at zero
        assign inc = issue && writes_rd && rd == reg_addr_t'(i);
        assign dec = (i != 0) && wb_valid && wb_addr == reg_addr_t'(i);

        always_ff @(posedge clk) begin
            if (rst) begin
                pending[i] <= '0;
            end else if (inc && !dec) begin
                pending[i] <= pending[i] + 1'b1;
            end else if (dec && !inc) begin
                pending[i] <= pending[i] - 1'b1;
            end
        end

        // Writeback only for a register with a write in flight
        assert property (@(posedge clk) disable iff (rst) dec |-> pending[i] != '0)
            else $error("Writeback to x%0d with no pending write", i);

        assert property (@(posedge clk) disable iff (rst)
            inc && !dec |-> pending[i] < max_pending)
            else $error("Pending count overflow on x%0d", i);
    end

    always_comb begin
        all_clear = 1'b1;
        for (int i = 0; i < reg_count; i++) begin
            if (pending[i] != '0) begin
                all_clear = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_decode.sv ====
`default_nettype none

module rv_decode
    import rv_decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       in_valid,
    input  reg_value_t in_inst,
    input  reg_value_t in_pc,
    output logic       in_ready,

    output logic       ex_valid,
    input  logic       ex_ready,
    output exec_type_t ex_type,
    output funct3_t    ex_funct3,
    output logic       ex_alt,
    output reg_addr_t  ex_rd,
    output reg_value_t ex_operand_a,
    output reg_value_t ex_operand_b,
    output reg_value_t ex_store_value,
    output reg_value_t ex_pc,

    input  logic       wb_valid,
    input  reg_addr_t  wb_addr,
    input  reg_value_t wb_value,

    output logic       halted,
    output logic       faulted,
    output logic       finished
);

    reg_addr_t   rd, rs1, rs2;
    funct3_t     funct3;
    logic        alt;
    reg_value_t  imm;
    inst_class_t inst_class;
    logic        uses_rs1, uses_rs2, writes_rd;
    reg_value_t  rs1_value, rs2_value;
    logic        clearing, issue_ok, all_clear, issue;

    decode_fields u_fields (
        .inst       (in_inst),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .funct3     (funct3),
        .alt        (alt),
        .imm        (imm),
        .inst_class (inst_class),
        .uses_rs1   (uses_rs1),
        .uses_rs2   (uses_rs2),
        .writes_rd  (writes_rd)
    );

    decode_reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rd_addr_a  (rs1),
        .rd_addr_b  (rs2),
        .rd_value_a (rs1_value),
        .rd_value_b (rs2_value),
        .wr_en      (wb_valid),
        .wr_addr    (wb_addr),
        .wr_value   (wb_value),
        .clearing   (clearing)
    );

    decode_scoreboard u_scoreboard (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .uses_rs1  (uses_rs1),
        .uses_rs2  (uses_rs2),
        .writes_rd (writes_rd),
        .issue     (issue),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .issue_ok  (issue_ok),
        .all_clear (all_clear)
    );

    decode_control u_control (
        .clk            (clk),
        .rst            (rst),
        .in_valid       (in_valid),
        .in_pc          (in_pc),
        .in_ready       (in_ready),
        .clearing       (clearing),
        .issue_ok       (issue_ok),
        .all_clear      (all_clear),
        .issue          (issue),
        .rd             (rd),
        .funct3         (funct3),
        .alt            (alt),
        .imm            (imm),
        .inst_class     (inst_class),
        .writes_rd      (writes_rd),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value),
        .ex_valid       (ex_valid),
        .ex_ready       (ex_ready),
        .ex_type        (ex_type),
        .ex_funct3      (ex_funct3),
        .ex_alt         (ex_alt),
        .ex_rd          (ex_rd),
        .ex_operand_a   (ex_operand_a),
        .ex_operand_b   (ex_operand_b),
        .ex_store_value (ex_store_value),
        .ex_pc          (ex_pc),
        .halted         (halted),
        .faulted        (faulted),
        .finished       (finished)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;

    typedef logic [4:0] reg_addr_t;
    typedef logic [xlen-1:0] reg_value_t;
    typedef logic [2:0] funct3_t;

    // Up to two writes in flight per destination
    typedef logic [1:0] pend_count_t;
    localparam pend_count_t max_pending = 2'd2;

    // RV32I major opcodes, including the ones that fault here
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_FENCE  = 7'b0001111,
        OPC_IMM    = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    localparam funct3_t funct3_add = 3'b000;      // ADD/SUB, also ECALL/EBREAK group
    localparam funct3_t funct3_srl_sra = 3'b101;
    localparam logic [6:0] funct7_alt = 7'b0100000; // SUB and SRA

    // funct12 of EBREAK, ECALL is zero
    localparam logic [11:0] ebreak_funct12 = 12'h001;

    // Execute command kind
    typedef enum logic [1:0] {
        EXEC_ALU   = 2'b00,
        EXEC_LOAD  = 2'b01,
        EXEC_STORE = 2'b10
    } exec_type_t;

    // Instruction class seen by the stage
    typedef enum logic [2:0] {
        ALU_REG = 3'd0,
        ALU_IMM = 3'd1,
        UPPER   = 3'd2,     // LUI and AUIPC
        LOAD    = 3'd3,
        STORE   = 3'd4,
        HALT    = 3'd5,
        ILLEGAL = 3'd6
    } inst_class_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_decode \
    -f rv_decode.f \
    -o tb_rv_decode
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_rv_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== rv_decode.f ====
hdl/rv_decode_pkg.sv
hdl/decode_fields.sv
hdl/decode_reg_file.sv
hdl/decode_scoreboard.sv
hdl/decode_control.sv
hdl/rv_decode.sv
bench/tb_rv_decode.sv
